/* compile.f */
design/serial_pkg.sv
design/nonce_pkg.sv
design/command_receiver.sv
design/nonce_report_buffer.sv
design/response_transmitter.sv
design/serial_interface.sv
tb/clock_gen.sv
tb/tb_serial_interface.sv

/* run.sh */
#!/bin/sh
# Build and run the serial interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_serial_interface -f compile.f --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_serial_interface)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1

/* tb/tb_serial_interface.sv */
`timescale 1ns/1ps

module tb_serial_interface
	import serial_pkg::*;
	import nonce_pkg::*;
;

	localparam int WATCHDOG_CYCLES = 12 * REPORT_PERIOD + 4000;
	localparam int DRAIN_LIMIT     = 4000;

	logic clk, arst_n, tx_busy, job_ready, chip_enabled, reset_best_nonce;
	uart_byte_t rx, tx;
	nonce_report_t report;
	job_t job;

	uart_byte_t got_bytes[$];
	logic [7:0] exp_bytes[$];
	job_t exp_jobs[$];
	int got_idx = 0, exp_idx = 0, job_idx = 0, loads = 0, stop_loads;
	int pings_sent = 0, pings_seen = 0, busy_len;
	int tx_errors = 0, job_errors = 0, state_errors = 0;
	logic [31:0] job_word;
	string test_name = "reset";

	clock_gen clock_gen_i (.clk_o(clk));

	serial_interface serial_interface_i (
		.clk_i(clk), .arst_n_i(arst_n), .rx_i(rx), .tx_busy_i(tx_busy),
		.report_i(report), .job_ready_i(job_ready), .tx_o(tx), .job_o(job),
		.chip_enabled_o(chip_enabled), .reset_best_nonce_o(reset_best_nonce)
	);

	// Header, zero-extended upper bits_off, low bits_off, then the nonce MSB first
	function automatic void expected_report(input nonce_report_t rep);
		exp_bytes.push_back(REPORT_HEADER);
		exp_bytes.push_back({6'b0, rep.bits_off[9:8]});
		exp_bytes.push_back(rep.bits_off[7:0]);
		for (int i = NONCE_BYTES - 1; i >= 0; i--) begin
			exp_bytes.push_back(rep.nonce[i*8 +: 8]);
		end
	endfunction

	function automatic nonce_report_t random_report();
		logic [287:0] bits;
		for (int i = 0; i < 9; i++) begin
			bits = {bits[255:0], 32'($urandom)};
		end
		return nonce_report_t'(bits[$bits(nonce_report_t)-1:0]);
	endfunction

	task automatic check_tx_byte(input logic [7:0] expected, input uart_byte_t actual);
		if (actual.data !== expected) begin
			tx_errors++;
			$display("** Error [%s] tx_o byte: expected %h, actual %h",
				test_name, expected, actual.data);
		end
	endtask

	task automatic check_job(input job_t expected, input job_t actual);
		if (actual !== expected) begin
			job_errors++;
			$display("** Error [%s] job_o: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic check_enabled(input logic expected);
		if (chip_enabled !== expected) begin
			state_errors++;
			$display("** Error [%s] chip_enabled_o: expected %b, actual %b",
				test_name, expected, chip_enabled);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic send_byte(input logic [7:0] data_byte);
		@(posedge clk);
		#2;
		rx = '{strobe: 1'b1, data: data_byte};
		@(posedge clk);
		#2;
		rx.strobe = 1'b0;
	endtask

	task automatic send_job(input logic [31:0] word, input int count);
		send_byte(CMD_JOB);
		for (int i = 0; i < count; i++) begin
			send_byte(word[31 - 8*i -: 8]);
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while ((exp_idx < exp_bytes.size() || pings_seen < pings_sent ||
			got_idx < got_bytes.size()) && n < DRAIN_LIMIT) begin
			@(posedge clk);
			n++;
		end
		#2;
		if (n >= DRAIN_LIMIT) begin
			state_errors++;
			$display("Test %s: expected tx_o bytes never arrived", test_name);
		end
	endtask

	task automatic wait_for_loads(input int target);
		int n;
		n = 0;
		while (loads < target && n < 2 * REPORT_PERIOD) begin
			@(posedge clk);
			n++;
		end
		#2;
		if (loads < target) begin
			state_errors++;
			$display("Test %s: no report was started in time", test_name);
		end
	endtask

	// UART busy model
	initial begin
		tx_busy = 1'b0;
		forever begin
			@(negedge clk);
			if (tx.strobe) begin
				busy_len = 3 + int'($urandom_range(9, 0));
				@(posedge clk);
				#2;
				tx_busy = 1'b1;
				repeat (busy_len) @(posedge clk);
				#2;
				tx_busy = 1'b0;
			end
		end
	end

	// Monitor samples mid-cycle
	always @(negedge clk) begin
		if (arst_n) begin
			if (tx.strobe) begin
				got_bytes.push_back(tx);
				if (tx_busy) begin
					tx_errors++;
					$display("Test %s: tx_o strobed while tx_busy_i was high", test_name);
				end
			end
			if (reset_best_nonce) begin
				loads++;
				expected_report(report);
			end
			if (job.valid && job_idx < exp_jobs.size()) begin
				check_job(exp_jobs[job_idx], job);
				job_idx++;
			end else if (job.valid) begin
				job_errors++;
				$display("Test %s: job_o.valid pulsed with no job expected", test_name);
			end
		end
	end

	// A started report owns the line until its last byte, so pings come after it
	always @(posedge clk) begin
		while (got_idx < got_bytes.size()) begin
			if (exp_idx < exp_bytes.size()) begin
				check_tx_byte(exp_bytes[exp_idx], got_bytes[got_idx]);
				exp_idx++;
			end else if (pings_seen < pings_sent) begin
				check_tx_byte(PING_REPLY, got_bytes[got_idx]);
				pings_seen++;
			end else begin
				tx_errors++;
				$display("Test %s: unexpected byte %h on tx_o", test_name, got_bytes[got_idx].data);
			end
			got_idx++;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
		$display("Errors: tx %0d, job %0d, state %0d", tx_errors, job_errors, state_errors);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		rx = '0;
		report = '0;
		job_ready = 1'b0;
		arst_n = 1'b0;
		void'($urandom(72145));
		wait_cycles(8);
		arst_n = 1'b1;

		test_name = "ping";
		send_byte(CMD_PING);
		pings_sent++;
		wait_drained();
		check_enabled(1'b0);

		test_name = "report";
		report = random_report();
		send_byte(CMD_START);
		wait_cycles(2);
		check_enabled(1'b1);
		wait_for_loads(2);
		wait_drained();

		test_name = "job";
		job_ready = 1'b1;
		job_word = $urandom;
		exp_jobs.push_back('{valid: 1'b1, word: job_word});
		send_job(job_word, 4);
		wait_cycles(4);
		job_ready = 1'b0;
		send_job($urandom, 4);
		wait_cycles(4);
		job_ready = 1'b1;

		test_name = "timeout";
		send_job($urandom, 2);
		wait_cycles(RX_TIMEOUT + 8);
		send_byte(CMD_PING);
		pings_sent++;
		wait_drained();

		test_name = "interleave_stop";
		report = random_report();
		wait_for_loads(loads + 1);
		wait_cycles(30);
		send_byte(CMD_PING);
		pings_sent++;
		send_byte(CMD_STOP);
		wait_drained();
		check_enabled(1'b0);
		stop_loads = loads;
		wait_cycles(2 * REPORT_PERIOD);
		if (loads != stop_loads) begin
			state_errors++;
			$display("Test %s: a report started after CMD_STOP", test_name);
		end
		wait_drained();
		if (job_idx != exp_jobs.size()) begin
			job_errors++;
			$display("An expected job never appeared on job_o");
		end

		$display("Errors: tx %0d, job %0d, state %0d", tx_errors, job_errors, state_errors);
		if (tx_errors + job_errors + state_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* tb/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

endmodule

/* design/serial_interface.sv */
`timescale 1ns/1ps

module serial_interface
	import serial_pkg::*;
	import nonce_pkg::*;
(
	input  logic          clk_i,
	input  logic          arst_n_i,
	input  uart_byte_t    rx_i,
	input  logic          tx_busy_i,
	input  nonce_report_t report_i,
	input  logic          job_ready_i,
	output uart_byte_t    tx_o,
	output job_t          job_o,
	output logic          chip_enabled_o,
	output logic          reset_best_nonce_o
);

	logic       ping_req;
	logic       chip_enabled;
	logic       load;
	logic       shift;
	logic [7:0] report_byte;
	logic       last_byte;

	assign chip_enabled_o     = chip_enabled;
	// Latching a report also restarts the core's best-nonce search
	assign reset_best_nonce_o = load;

	command_receiver command_receiver_i (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.rx_i           (rx_i),
		.job_ready_i    (job_ready_i),
		.job_o          (job_o),
		.ping_o         (ping_req),
		.chip_enabled_o (chip_enabled)
	);

	nonce_report_buffer nonce_report_buffer_i (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.report_i (report_i),
		.load_i   (load),
		.shift_i  (shift),
		.byte_o   (report_byte),
		.last_o   (last_byte)
	);

	response_transmitter response_transmitter_i (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.ping_i         (ping_req),
		.chip_enabled_i (chip_enabled),
		.tx_busy_i      (tx_busy_i),
		.report_byte_i  (report_byte),
		.last_byte_i    (last_byte),
		.tx_o           (tx_o),
		.load_o         (load),
		.shift_o        (shift)
	);

endmodule

/* design/response_transmitter.sv */
`timescale 1ns/1ps

module response_transmitter
	import serial_pkg::*;
	import nonce_pkg::*;
(
	input  logic       clk_i,
	input  logic       arst_n_i,
	input  logic       ping_i,
	input  logic       chip_enabled_i,
	input  logic       tx_busy_i,
	input  logic [7:0] report_byte_i,
	input  logic       last_byte_i,
	output uart_byte_t tx_o,
	output logic       load_o,
	output logic       shift_o
);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_REPORT,
		TX_PING
	} tx_state_e;

	tx_state_e           state;
	logic                ping_pending;
	logic                report_pending;
	logic [PERIOD_W-1:0] period_cnt;
	logic                period_done;
	logic                ping_sent;

	assign period_done = (period_cnt == PERIOD_W'(REPORT_PERIOD - 1));
	assign ping_sent   = (state == TX_PING) && tx_o.strobe;

	// Ping wins over a pending report when both wait in idle
	assign load_o = (state == TX_IDLE) && !ping_pending && report_pending;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			period_cnt     <= '0;
			report_pending <= 1'b0;
			ping_pending   <= 1'b0;
		end else begin
			if (period_done) begin
				period_cnt <= '0;
			end else begin
				period_cnt <= period_cnt + 1'b1;
			end
			// Disabled chip never keeps a report waiting
			report_pending <= chip_enabled_i && (period_done || (report_pending && !load_o));
			ping_pending   <= ping_i || (ping_pending && !ping_sent);
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= TX_IDLE;
		end else begin
			case (state)
				TX_IDLE: begin
					if (ping_pending) begin
						state <= TX_PING;
					end else if (load_o) begin
						state <= TX_REPORT;
					end
				end
				TX_REPORT: begin
					if (tx_o.strobe && last_byte_i) begin
						state <= TX_IDLE;
					end
				end
				TX_PING: begin
					if (tx_o.strobe) begin
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// UART busy rises the cycle after a strobe, so the strobe follows busy directly
	always_comb begin
		tx_o    = '0;
		shift_o = 1'b0;
		case (state)
			TX_REPORT: begin
				tx_o.strobe = !tx_busy_i;
				tx_o.data   = report_byte_i;
				shift_o     = !tx_busy_i;
			end
			TX_PING: begin
				tx_o.strobe = !tx_busy_i;
				tx_o.data   = PING_REPLY;
			end
			default: ;
		endcase
	end

endmodule

/* design/nonce_report_buffer.sv */
`timescale 1ns/1ps

module nonce_report_buffer
	import serial_pkg::*;
	import nonce_pkg::*;
(
	input  logic          clk_i,
	input  logic          arst_n_i,
	input  nonce_report_t report_i,
	input  logic          load_i,
	input  logic          shift_i,
	output logic [7:0]    byte_o,
	output logic          last_o
);

	logic [REPORT_BYTES*8-1:0] frame_q;
	logic [REPORT_CNT_W-1:0]   bytes_left;
	logic [15:0]               bits_off_field;

	// Upper bits of bits_off go out zero-extended in their own byte
	assign bits_off_field = 16'(report_i.bits_off);

	always_ff @(posedge clk_i) begin
		if (load_i) begin
			frame_q <= {REPORT_HEADER, bits_off_field, report_i.nonce};
		end else if (shift_i) begin
			frame_q <= {frame_q[REPORT_BYTES*8-9:0], 8'h00};
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bytes_left <= '0;
		end else if (load_i) begin
			bytes_left <= REPORT_CNT_W'(REPORT_BYTES);
		end else if (shift_i && bytes_left != '0) begin
			bytes_left <= bytes_left - 1'b1;
		end
	end

	assign byte_o = frame_q[REPORT_BYTES*8-1 -: 8];
	assign last_o = (bytes_left == REPORT_CNT_W'(1));

endmodule

/* design/command_receiver.sv */
`timescale 1ns/1ps

module command_receiver
	import serial_pkg::*;
	import nonce_pkg::*;
(
	input  logic       clk_i,
	input  logic       arst_n_i,
	input  uart_byte_t rx_i,
	input  logic       job_ready_i,
	output job_t       job_o,
	output logic       ping_o,
	output logic       chip_enabled_o
);

	typedef enum logic [1:0] {
		RX_OPCODE,
		RX_PAYLOAD,
		RX_DROP
	} rx_state_e;

	rx_state_e             state;
	logic [RX_IDLE_W-1:0]  idle_cnt;
	logic [JOB_CNT_W-1:0]  byte_cnt;
	logic [31:0]           job_word;
	logic                  job_valid;

	assign job_o = '{valid: job_valid, word: job_word};

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state          <= RX_OPCODE;
			idle_cnt       <= '0;
			byte_cnt       <= '0;
			ping_o         <= 1'b0;
			job_valid      <= 1'b0;
			chip_enabled_o <= 1'b0;
		end else begin
			ping_o    <= 1'b0;
			job_valid <= 1'b0;
			case (state)
				// A dropped frame is already closed, so its next byte is an opcode
				RX_OPCODE, RX_DROP: begin
					state    <= RX_OPCODE;
					idle_cnt <= '0;
					byte_cnt <= '0;
					if (rx_i.strobe) begin
						case (cmd_e'(rx_i.data))
							CMD_START: chip_enabled_o <= 1'b1;
							CMD_STOP:  chip_enabled_o <= 1'b0;
							CMD_PING:  ping_o <= 1'b1;
							CMD_JOB:   state <= RX_PAYLOAD;
							default:   ;
						endcase
					end
				end
				RX_PAYLOAD: begin
					if (rx_i.strobe) begin
						idle_cnt <= '0;
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == JOB_CNT_W'(JOB_BYTES - 1)) begin
							// Job memory not ready means the job is lost
							job_valid <= job_ready_i;
							state     <= RX_OPCODE;
						end
					end else if (idle_cnt == RX_IDLE_W'(RX_TIMEOUT - 1)) begin
						state <= RX_DROP;
					end else begin
						idle_cnt <= idle_cnt + 1'b1;
					end
				end
				default: state <= RX_OPCODE;
			endcase
		end
	end

	// First payload byte ends up most significant
	always_ff @(posedge clk_i) begin
		if (state == RX_PAYLOAD && rx_i.strobe) begin
			job_word <= {job_word[23:0], rx_i.data};
		end
	end

endmodule

/* design/nonce_pkg.sv */
package nonce_pkg;

	localparam int NONCE_W     = 256;
	localparam int NONCE_BYTES = NONCE_W / 8;
	localparam int BITS_OFF_W  = 10;

	// Header, two bits_off bytes, then the nonce
	localparam int REPORT_BYTES = NONCE_BYTES + 3;
	localparam int REPORT_CNT_W = $clog2(REPORT_BYTES + 1);

	typedef struct packed {
		logic [BITS_OFF_W-1:0] bits_off;
		logic [NONCE_W-1:0]    nonce;
	} nonce_report_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] word;
	} job_t;

	localparam int REPORT_PERIOD = 1500;
	localparam int PERIOD_W      = $clog2(REPORT_PERIOD);

endpackage

/* design/serial_pkg.sv */
package serial_pkg;

	// Any other byte in opcode position is ignored
	typedef enum logic [7:0] {
		CMD_START = 8'h01,
		CMD_STOP  = 8'h02,
		CMD_PING  = 8'h03,
		CMD_JOB   = 8'h04
	} cmd_e;

	// One byte crossing the UART boundary
	typedef struct packed {
		logic       strobe;
		logic [7:0] data;
	} uart_byte_t;

	localparam logic [7:0] PING_REPLY    = 8'h50;
	localparam logic [7:0] REPORT_HEADER = 8'hA5;

	// Payload bytes following CMD_JOB
	localparam int JOB_BYTES = 4;
	localparam int JOB_CNT_W = $clog2(JOB_BYTES);

	// Largest gap allowed between two bytes of one frame
	localparam int RX_TIMEOUT = 64;
	localparam int RX_IDLE_W  = $clog2(RX_TIMEOUT);

endpackage
